//--- compile.f
logic/cpuPkg.sv
logic/memPkg.sv
logic/memReqIf.sv
logic/accessBuffer.sv
logic/memSequencer.sv
logic/byteCounter.sv
logic/wordAssembler.sv
logic/dataRam.sv
logic/lsuMemTop.sv
testbench/lsuMemTb.sv

//--- logic/accessBuffer.sv
`timescale 1ns/10ps

module accessBuffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         slbEn,
    input  logic                         slbStore,
    input  logic [cpuPkg::addrWidth-1:0] slbAddr,
    input  logic [cpuPkg::dataWidth-1:0] slbData,
    input  cpuPkg::accessLen             slbLen,
    input  logic [cpuPkg::nickWidth-1:0] slbNick,
    output logic                         slbReady,
    output logic                         slbDone,
    output logic [cpuPkg::dataWidth-1:0] slbRdata,
    output logic [cpuPkg::nickWidth-1:0] slbDoneNick,
    memReqIf.issuer                      mem
);

    logic                         occupied;
    logic                         issued; // en already sent for this entry.
    logic                         enQ;
    logic                         storeQ;
    logic [cpuPkg::addrWidth-1:0] addrQ;
    logic [cpuPkg::dataWidth-1:0] dataQ;
    cpuPkg::accessLen             lenQ;
    logic [cpuPkg::nickWidth-1:0] nickQ;
    logic                         accept;

    assign slbReady = ~occupied;
    assign accept   = slbEn & slbReady;

    assign mem.en    = enQ;
    assign mem.store = storeQ;
    assign mem.addr  = addrQ;
    assign mem.wdata = dataQ;
    assign mem.len   = lenQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied    <= 1'b0;
            issued      <= 1'b0;
            enQ         <= 1'b0;
            slbDone     <= 1'b0;
            slbRdata    <= '0;
            slbDoneNick <= '0;
        end else if (rdy) begin
            slbDone <= mem.done;
            if (mem.done) begin
                slbRdata    <= mem.rdata;
                slbDoneNick <= nickQ;
                occupied    <= 1'b0; // entry free again.
                issued      <= 1'b0;
            end else if (accept) begin
                occupied <= 1'b1;
            end
            if (occupied && !issued && !mem.busy) begin
                enQ    <= 1'b1;
                issued <= 1'b1;
            end else begin
                enQ <= 1'b0;
            end
        end
    end

    // request payload, held while the entry is occupied.
    always_ff @(posedge clk) begin
        if (rdy && accept) begin
            storeQ <= slbStore;
            addrQ  <= slbAddr;
            dataQ  <= slbData;
            lenQ   <= slbLen;
            nickQ  <= slbNick;
        end
    end

    // a refused request stays on slbEn until it is taken.
    slbHoldsRequest: assert property (@(posedge clk) disable iff (rst)
        (rdy && slbEn && !slbReady) |=> slbEn);

    enNotWhileBusy: assert property (@(posedge clk) disable iff (rst)
        mem.en |-> !mem.busy);

endmodule

//--- logic/byteCounter.sv
`timescale 1ns/10ps

module byteCounter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rdy,
    input  logic                            load,
    input  logic                            step,
    input  cpuPkg::accessLen                len,
    input  memPkg::seqState                 state,
    output logic [cpuPkg::byteIdxWidth-1:0] count,
    output logic                            last
);

    logic [cpuPkg::byteIdxWidth:0] total; // bytes in this access.

    always_comb begin
        case (len)
            cpuPkg::lenByte: total = 'd1;
            cpuPkg::lenHalf: total = 'd2;
            default:         total = 'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (rdy) begin
            if (load) begin
                count <= '0;
            end else if (step) begin
                count <= count + 1'b1;
            end
        end
    end

    assign last = ({1'b0, count} == total - 1'b1);

    countWithinTotal: assert property (@(posedge clk) disable iff (rst)
        (state == memPkg::readBytes || state == memPkg::writeBytes)
        |-> ({1'b0, count} < total));

endmodule

//--- logic/cpuPkg.sv
package cpuPkg;

    localparam int addrWidth = 32;
    localparam int dataWidth = 32;
    localparam int nickWidth = 4; // load/store buffer entry tag.

    // byte lane select within one data word.
    localparam int byteIdxWidth = $clog2(dataWidth / 8);

    // access length as seen on the load/store side.
    typedef enum logic [1:0] {
        lenByte = 2'd0, // 1 byte.
        lenHalf = 2'd1, // 2 bytes.
        lenWord = 2'd2  // 4 bytes.
    } accessLen;

endpackage

//--- logic/dataRam.sv
`timescale 1ns/10ps

module dataRam #(
    parameter int ramDepth = memPkg::ramDepthDefault
) (
    input  logic                        clk,
    input  logic                        we,
    input  logic [$clog2(ramDepth)-1:0] addr,
    input  logic [7:0]                  wbyte,
    output logic [7:0]                  rbyte
);

    logic [7:0] mem [ramDepth];

    // read returns the old byte on a write to the same address.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wbyte;
        end
        rbyte <= mem[addr];
    end

endmodule

//--- logic/lsuMemTop.sv
`timescale 1ns/10ps

module lsuMemTop #(
    parameter int ramDepth = memPkg::ramDepthDefault
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         slbEn,
    input  logic                         slbStore,
    input  logic [cpuPkg::addrWidth-1:0] slbAddr,
    input  logic [cpuPkg::dataWidth-1:0] slbData,
    input  cpuPkg::accessLen             slbLen,
    input  logic [cpuPkg::nickWidth-1:0] slbNick,
    output logic                         slbReady,
    output logic                         slbDone,
    output logic [cpuPkg::dataWidth-1:0] slbRdata,
    output logic [cpuPkg::nickWidth-1:0] slbDoneNick
);

    localparam int ramAw = $clog2(ramDepth);

    memReqIf memIf ();

    memPkg::seqState                 seqState;
    logic                            cntLoad;
    logic                            cntStep;
    cpuPkg::accessLen                cntLen;
    logic [cpuPkg::byteIdxWidth-1:0] cntCount;
    logic                            cntLast;
    logic                            asmClear;
    logic                            asmCapture;
    logic [cpuPkg::byteIdxWidth-1:0] byteIndex;
    logic                            ramWe;
    logic [ramAw-1:0]                ramAddr;
    logic [7:0]                      ramWbyte;
    logic [7:0]                      ramRbyte;

    accessBuffer i_buffer (
        .clk(clk), .rst(rst), .rdy(rdy),
        .slbEn(slbEn), .slbStore(slbStore), .slbAddr(slbAddr),
        .slbData(slbData), .slbLen(slbLen), .slbNick(slbNick),
        .slbReady(slbReady), .slbDone(slbDone), .slbRdata(slbRdata),
        .slbDoneNick(slbDoneNick), .mem(memIf.issuer)
    );

    memSequencer #(.ramDepth(ramDepth)) i_seq (
        .clk(clk), .rst(rst), .rdy(rdy), .mem(memIf.server), .state(seqState),
        .cntLoad(cntLoad), .cntStep(cntStep), .cntLen(cntLen),
        .cntCount(cntCount), .cntLast(cntLast),
        .asmClear(asmClear), .asmCapture(asmCapture), .byteIndex(byteIndex),
        .ramWe(ramWe), .ramAddr(ramAddr)
    );

    byteCounter i_counter (
        .clk(clk), .rst(rst), .rdy(rdy), .load(cntLoad), .step(cntStep),
        .len(cntLen), .state(seqState), .count(cntCount), .last(cntLast)
    );

    // load word goes straight back on the request interface.
    wordAssembler i_assembler (
        .clk(clk), .rst(rst), .rdy(rdy), .clear(asmClear), .capture(asmCapture),
        .byteIndex(byteIndex), .readByte(ramRbyte), .wdataIn(memIf.wdata),
        .writeByte(ramWbyte), .word(memIf.rdata)
    );

    dataRam #(.ramDepth(ramDepth)) i_ram (
        .clk(clk), .we(ramWe), .addr(ramAddr), .wbyte(ramWbyte), .rbyte(ramRbyte)
    );

endmodule

//--- logic/memPkg.sv
package memPkg;

    // states of the byte sequencer.
    typedef enum logic [2:0] {
        idle       = 3'd0,
        readBytes  = 3'd1, // one ram read per byte.
        readTail   = 3'd2, // last read byte arrives from the ram.
        writeBytes = 3'd3, // one ram write per byte.
        finish     = 3'd4  // done pulse.
    } seqState;

    // data ram size in bytes, a power of two.
    localparam int ramDepthDefault = 1024;

endpackage

//--- logic/memReqIf.sv
`timescale 1ns/10ps

interface memReqIf;

    logic                          en;    // one-cycle request strobe.
    logic                          store; // high for a store.
    logic [cpuPkg::addrWidth-1:0]  addr;
    logic [cpuPkg::dataWidth-1:0]  wdata;
    cpuPkg::accessLen              len;
    logic                          busy;  // memory side working.
    logic                          done;  // one-cycle completion.
    logic [cpuPkg::dataWidth-1:0]  rdata; // load data, valid with done.

    modport issuer (
        output en,
        output store,
        output addr,
        output wdata,
        output len,
        input  busy,
        input  done,
        input  rdata
    );

    modport server (
        input  en,
        input  store,
        input  addr,
        input  wdata,
        input  len,
        output busy,
        output done,
        output rdata
    );

endinterface

//--- logic/memSequencer.sv
`timescale 1ns/10ps

module memSequencer #(
    parameter int ramDepth = memPkg::ramDepthDefault
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rdy,
    memReqIf.server                         mem,
    output memPkg::seqState                 state,
    output logic                            cntLoad,
    output logic                            cntStep,
    output cpuPkg::accessLen                cntLen,
    input  logic [cpuPkg::byteIdxWidth-1:0] cntCount,
    input  logic                            cntLast,
    output logic                            asmClear,
    output logic                            asmCapture,
    output logic [cpuPkg::byteIdxWidth-1:0] byteIndex,
    output logic                            ramWe,
    output logic [$clog2(ramDepth)-1:0]     ramAddr
);

    localparam int ramAw = $clog2(ramDepth);

    logic [cpuPkg::addrWidth-1:0]    baseAddr;
    logic                            storeQ;
    cpuPkg::accessLen                lenQ;
    logic [cpuPkg::byteIdxWidth-1:0] lagIdx; // lane of the byte leaving the ram.
    logic [cpuPkg::addrWidth-1:0]    byteAddr;
    logic [ramAw-1:0]                ramAddrHeld;
    logic                            start;

    assign start = (state == memPkg::idle) && mem.en;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::idle;
        end else if (rdy) begin
            case (state)
                memPkg::idle: begin
                    if (mem.en) begin
                        state <= mem.store ? memPkg::writeBytes : memPkg::readBytes;
                    end
                end
                memPkg::readBytes: begin
                    if (cntLast) begin
                        state <= memPkg::readTail;
                    end
                end
                memPkg::readTail: state <= memPkg::finish;
                memPkg::writeBytes: begin
                    if (cntLast) begin
                        state <= memPkg::finish;
                    end
                end
                default: state <= memPkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (start) begin
                baseAddr <= mem.addr;
                storeQ   <= mem.store;
                lenQ     <= mem.len;
            end
            lagIdx      <= cntCount;
            ramAddrHeld <= byteAddr[ramAw-1:0];
        end
    end

    assign mem.busy = (state != memPkg::idle);
    assign mem.done = (state == memPkg::finish);

    assign cntLoad = start;
    assign cntStep = !cntLast && (state == memPkg::readBytes || state == memPkg::writeBytes);
    assign cntLen  = lenQ;

    assign asmClear   = start;
    assign asmCapture = (state == memPkg::readTail)
                     || (state == memPkg::readBytes && cntCount != '0);
    assign byteIndex  = (storeQ && state == memPkg::writeBytes) ? cntCount : lagIdx;

    // wraps at ramDepth.
    assign byteAddr = baseAddr + cpuPkg::addrWidth'(cntCount);
    assign ramWe    = rdy && (state == memPkg::writeBytes);
    // a frozen cycle re-reads the last address so rbyte keeps its byte.
    assign ramAddr  = rdy ? byteAddr[ramAw-1:0] : ramAddrHeld;

    enOnlyWhenIdle: assert property (@(posedge clk) disable iff (rst)
        mem.en |-> state == memPkg::idle);

endmodule

//--- logic/wordAssembler.sv
`timescale 1ns/10ps

module wordAssembler (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rdy,
    input  logic                            clear,
    input  logic                            capture,
    input  logic [cpuPkg::byteIdxWidth-1:0] byteIndex,
    input  logic [7:0]                      readByte,
    input  logic [cpuPkg::dataWidth-1:0]    wdataIn,
    output logic [7:0]                      writeByte,
    output logic [cpuPkg::dataWidth-1:0]    word
);

    // lanes not captured stay zero, so short loads come out zero-extended.
    always_ff @(posedge clk) begin
        if (rst) begin
            word <= '0;
        end else if (rdy) begin
            if (clear) begin
                word <= '0;
            end else if (capture) begin
                word[byteIndex*8 +: 8] <= readByte; // lane 0 is the lowest address.
            end
        end
    end

    assign writeByte = wdataIn[byteIndex*8 +: 8];

endmodule

//--- run.sh
#!/bin/sh
# Builds lsuMemTb with Verilator, runs it and checks the log for the fail message.
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module lsuMemTb -f compile.f -o lsuMemSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lsuMemSim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$log"; then
    exit 1
fi
exit 0

//--- testbench/lsuMemTb.sv
`timescale 1ns/10ps

module lsuMemTb;

    localparam int ramDepth = 256; // small, so random accesses overlap.
    localparam int ramAw = $clog2(ramDepth);
    localparam int timeoutCycles = 50;

    logic                         clk, rst, rdy, slbEn, slbStore, slbReady, slbDone;
    logic [cpuPkg::addrWidth-1:0] slbAddr;
    logic [cpuPkg::dataWidth-1:0] slbData, slbRdata;
    cpuPkg::accessLen             slbLen;
    logic [cpuPkg::nickWidth-1:0] slbNick, slbDoneNick;

    logic [7:0]                   refMem [ramDepth];
    logic                         isLoadQ [$]; // every request ever sent, in order.
    logic [cpuPkg::nickWidth-1:0] nickQ [$];
    logic [cpuPkg::dataWidth-1:0] dataQ [$];
    logic [cpuPkg::addrWidth-1:0] storedAddr [$];
    int                           storedLen [$];
    int                           readPtr; // oldest outstanding request.
    logic                         popPending, stallOn, stallArmed, timedOut;
    int                           stallLeft, errorCount, errorBase, testCount, failedTests;

    lsuMemTop #(.ramDepth(ramDepth)) i_dut (.*);

    always #2 clk = ~clk;

    function automatic int byteCount(input cpuPkg::accessLen len);
        case (len)
            cpuPkg::lenByte: return 1;
            cpuPkg::lenHalf: return 2;
            default:         return 4;
        endcase
    endfunction

    function automatic cpuPkg::accessLen lenFromCode(input int code);
        case (code)
            0:       return cpuPkg::lenByte;
            1:       return cpuPkg::lenHalf;
            default: return cpuPkg::lenWord;
        endcase
    endfunction

    // little-endian, zero-extended, wrapping at ramDepth.
    function automatic logic [31:0] modelLoad(input logic [31:0] addr, input int n);
        logic [31:0] word;
        logic [31:0] byteAddr;
        word = '0;
        for (int i = 0; i < n; i++) begin
            byteAddr = addr + i;
            word[i*8 +: 8] = refMem[byteAddr[ramAw-1:0]];
        end
        return word;
    endfunction

    task automatic reportMismatch(input string msg);
        errorCount++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic stepWatched(inout int cycles, input string what);
        @(negedge clk);
        cycles++;
        if (cycles >= timeoutCycles && !timedOut) begin
            timedOut = 1'b1;
            $display("timeout after %0d cycles %s", timeoutCycles, what);
        end
    endtask

    task automatic sendRequest(input logic store, input logic [31:0] addr,
                               input logic [31:0] data, input cpuPkg::accessLen len,
                               input logic [3:0] nick, input logic holdEarly);
        int          cycles;
        logic        sawReady;
        logic [31:0] byteAddr;
        cycles = 0;
        while (!holdEarly && !slbReady && !timedOut) stepWatched(cycles, "waiting for slbReady");
        if (!timedOut) begin
            slbEn    = 1'b1;
            slbStore = store;
            slbAddr  = addr;
            slbData  = data;
            slbLen   = len;
            slbNick  = nick;
            isLoadQ.push_back(!store);
            nickQ.push_back(nick);
            dataQ.push_back(store ? '0 : modelLoad(addr, byteCount(len)));
            if (store) begin
                for (int i = 0; i < byteCount(len); i++) begin
                    byteAddr = addr + i;
                    refMem[byteAddr[ramAw-1:0]] = data[i*8 +: 8];
                end
            end
            sawReady = slbReady;
            cycles = 0;
            // taken once slbReady has been seen high and then falls.
            while (!(sawReady && !slbReady) && !timedOut) begin
                if (slbReady) sawReady = 1'b1;
                stepWatched(cycles, "waiting for acceptance");
            end
            slbEn = 1'b0;
        end
    endtask

    task automatic waitDone();
        int cycles;
        cycles = 0;
        while (!slbDone && !timedOut) stepWatched(cycles, "waiting for slbDone");
        while (slbDone && !timedOut) stepWatched(cycles, "waiting for slbDone to clear");
    endtask

    task automatic randomOp();
        logic [31:0]      rnd;
        int               pick;
        int               codes;
        cpuPkg::accessLen len;
        rnd = $urandom;
        if (storedAddr.size() == 0 || rnd[0]) begin
            len = lenFromCode($urandom % 3);
            storedAddr.push_back($urandom % ramDepth);
            storedLen.push_back(byteCount(len));
            sendRequest(1'b1, storedAddr[storedAddr.size()-1], $urandom, len, rnd[7:4], 1'b0);
        end else begin
            pick = $urandom % storedAddr.size();
            codes = (storedLen[pick] == 4) ? 3 : storedLen[pick]; // stay inside written bytes.
            len = lenFromCode($urandom % codes);
            sendRequest(1'b0, storedAddr[pick], '0, len, rnd[7:4], 1'b0);
        end
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (errorCount != errorBase || timedOut) begin
            failedTests++;
            $display("test %0d %s: FAILED", testCount, name);
        end else begin
            $display("test %0d %s: ok", testCount, name);
        end
        errorBase = errorCount;
    endtask

    always @(posedge clk) popPending <= !rst && rdy && slbDone;
    always @(posedge clk) stallArmed <= stallOn;

    always @(negedge clk) begin
        if (popPending) readPtr <= readPtr + 1;
    end

    // random rdy gaps of one to four cycles.
    initial begin
        rdy = 1'b1;
        stallLeft = 0;
        forever begin
            @(negedge clk);
            if (!stallArmed) begin
                stallLeft = 0;
            end else if (stallLeft == 0 && $urandom % 5 == 0) begin
                stallLeft = 1 + $urandom % 4;
            end
            rdy = (stallLeft == 0);
            if (stallLeft > 0) stallLeft--;
        end
    end

    nickMatches: assert property (@(posedge clk) disable iff (rst)
        slbDone |-> (readPtr < nickQ.size()) && slbDoneNick == nickQ[readPtr])
        else reportMismatch("completion nickname differs from the oldest request");

    loadDataMatches: assert property (@(posedge clk) disable iff (rst)
        (slbDone && readPtr < nickQ.size() && isLoadQ[readPtr]) |-> slbRdata == dataQ[readPtr])
        else reportMismatch("load data differs from the reference memory");

    readyFallsOnAccept: assert property (@(posedge clk) disable iff (rst)
        (rdy && slbEn && slbReady) |=> !slbReady)
        else reportMismatch("slbReady stayed high after acceptance");

    readyRisesWithDone: assert property (@(posedge clk) disable iff (rst)
        $rose(slbReady) |-> slbDone)
        else reportMismatch("slbReady rose without slbDone");

    frozenWhileNotReady: assert property (@(posedge clk) disable iff (rst)
        !rdy |=> $stable(slbDone) && $stable(slbReady) && $stable(slbRdata)
                 && $stable(slbDoneNick))
        else reportMismatch("an output changed while rdy was low");

    initial begin
        void'($urandom(32'h3896));
        clk = 1'b0;
        rst = 1'b1;
        slbEn = 1'b0;
        slbStore = 1'b0;
        slbAddr = '0;
        slbData = '0;
        slbLen = cpuPkg::lenWord;
        slbNick = '0;
        stallOn = 1'b0;
        timedOut = 1'b0;
        readPtr = 0;
        errorCount = 0;
        errorBase = 0;
        testCount = 0;
        failedTests = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        sendRequest(1'b1, 32'h40, 32'hcafe_f00d, cpuPkg::lenWord, 4'h3, 1'b0);
        sendRequest(1'b0, 32'h40, '0, cpuPkg::lenWord, 4'h9, 1'b0);
        waitDone();
        endTest("word store then word load");

        sendRequest(1'b1, 32'h80, 32'h0, cpuPkg::lenWord, 4'h1, 1'b0);
        sendRequest(1'b1, 32'h81, 32'h55aa, cpuPkg::lenByte, 4'h2, 1'b0);
        sendRequest(1'b1, 32'h82, 32'h1234, cpuPkg::lenHalf, 4'h4, 1'b0);
        sendRequest(1'b0, 32'h80, '0, cpuPkg::lenWord, 4'h5, 1'b0);
        waitDone();
        endTest("byte and half stores merged");

        sendRequest(1'b0, 32'h83, '0, cpuPkg::lenByte, 4'h6, 1'b0);
        sendRequest(1'b0, 32'h81, '0, cpuPkg::lenHalf, 4'h7, 1'b0);
        sendRequest(1'b0, 32'h42, '0, cpuPkg::lenHalf, 4'h8, 1'b0);
        waitDone();
        endTest("short loads zero-extended");

        sendRequest(1'b1, 32'h90, 32'h8765_4321, cpuPkg::lenWord, 4'ha, 1'b0);
        sendRequest(1'b0, 32'h90, '0, cpuPkg::lenWord, 4'hb, 1'b1); // held while busy.
        waitDone();
        endTest("back-pressure on slbReady");

        stallOn = 1'b1;
        sendRequest(1'b1, ramDepth - 2, 32'hdead_beef, cpuPkg::lenWord, 4'hc, 1'b0);
        sendRequest(1'b0, ramDepth - 2, '0, cpuPkg::lenWord, 4'hd, 1'b0);
        sendRequest(1'b0, 32'h0, '0, cpuPkg::lenHalf, 4'he, 1'b0); // wrapped bytes.
        waitDone();
        endTest("rdy stalls during access");

        for (int k = 0; k < 200; k++) begin
            randomOp();
        end
        waitDone();
        stallOn = 1'b0;
        endTest("random stores and loads");

        $display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
        if (errorCount == 0 && failedTests == 0 && !timedOut) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
